// ==== verilog/block_game_pkg.sv ====
// Falling-block engine shared definitions
// Pixel widths, lane geometry and colour codes for the 160x120 plotter

package block_game_pkg;

	// ####################
	// Widths
	// ####################

	typedef logic [7:0] x_coord_t;   // Pixel column
	typedef logic [6:0] y_coord_t;   // Pixel row
	typedef logic [2:0] colour_t;    // Plotter colour code
	typedef logic [2:0] lane_t;      // Lane number, 7 marks none

	// ####################
	// Lane geometry
	// ####################

	localparam int NUM_LANES  = 5;
	localparam int LANE_X0    = 27;  // Left edge of lane 0
	localparam int LANE_PITCH = 21;  // Lane spacing, also row step
	localparam int TOP_Y      = 7;   // Spawn row
	localparam int BOTTOM_Y   = 91;  // Last live row
	localparam int BLOCK_SIZE = 20;  // Block edge in pixels

	// ####################
	// Colours
	// ####################

	localparam colour_t BLOCK_COLOUR = 3'd4;  // Red
	localparam colour_t BACKGROUND   = 3'd0;  // Black

endpackage

// ==== verilog/frame_timer.sv ====
// Hold delay between the draw and erase sweeps

`timescale 1ns/1ps

module frame_timer #(
	parameter int HOLD_CYCLES = 166
) (
	input  logic clock,
	input  logic reset,
	input  logic hold,
	output logic hold_done
);

	localparam int CNT_W = (HOLD_CYCLES > 1) ? $clog2(HOLD_CYCLES) : 1;

	logic [CNT_W-1:0] count;

	always_ff @(posedge clock)
	begin
		if (!reset || !hold)
			count <= '0;               // Restart for every hold
		else
			count <= count + 1'b1;
	end

	assign hold_done = hold && (count == CNT_W'(HOLD_CYCLES - 1));

endmodule

// ==== verilog/game_control.sv ====
// Round FSM for the falling-block engine
// Waits for a start press and release, then loops spawn, step, draw, hold, erase

`timescale 1ns/1ps

module game_control (
	input  logic clock,
	input  logic reset,
	input  logic start,
	input  logic sweep_done,
	input  logic hold_done,
	output logic capture,
	output logic advance,
	output logic sweep,
	output logic erase,
	output logic hold
);

	typedef enum logic [2:0] {
		PREPARE,
		IDLE,
		START_WAIT,
		SPAWN,
		ADVANCE,
		DRAW,
		HOLD,
		ERASE
	} state_t;

	state_t state;
	state_t state_next;

	// ####################
	// Next state
	// ####################

	always_comb
	begin
		state_next = state;
		unique case (state)
			PREPARE:    state_next = IDLE;
			IDLE:       state_next = start ? START_WAIT : IDLE;
			START_WAIT: state_next = start ? START_WAIT : SPAWN;  // Go on release
			SPAWN:      state_next = ADVANCE;
			ADVANCE:    state_next = DRAW;
			DRAW:       state_next = sweep_done ? HOLD : DRAW;
			HOLD:       state_next = hold_done ? ERASE : HOLD;
			ERASE:      state_next = sweep_done ? SPAWN : ERASE;
			default:    state_next = PREPARE;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (!reset)
			state <= PREPARE;
		else
			state <= state_next;
	end

	// ####################
	// Outputs
	// ####################

	assign capture = (state == SPAWN);              // Latch new random lane
	assign advance = (state == ADVANCE);            // Step blocks, load spawn
	assign sweep   = (state == DRAW) || (state == ERASE);
	assign erase   = (state == ERASE);
	assign hold    = (state == HOLD);

endmodule

// ==== verilog/lane_picker.sv ====
// Random spawn lane for the falling-block engine
// LFSR pick, history of two picks and a filter against stepping to a neighbour

`timescale 1ns/1ps

module lane_picker (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      capture,
	output block_game_pkg::x_coord_t  spawn_x
);
	import block_game_pkg::*;

	logic [7:0] lfsr;
	lane_t      pick;
	lane_t      current;
	lane_t      previous;
	lane_t      lane;

	// Taps 8,6,5,4 give the full 255 state cycle
	always_ff @(posedge clock)
	begin
		if (!reset)
			lfsr <= 8'h01;
		else
			lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
	end

	assign pick = lane_t'(lfsr % NUM_LANES);

	always_ff @(posedge clock)
	begin
		if (!reset)
		begin
			current  <= 3'd7;  // No lane yet
			previous <= 3'd7;
		end
		else if (capture)
		begin
			previous <= current;
			current  <= pick;
		end
	end

	// A step to the neighbouring lane is pushed one lane further
	always_comb
	begin
		if (int'(current) == int'(previous) + 1)
			lane = lane_t'((int'(current) + 1) % NUM_LANES);
		else if (int'(current) == int'(previous) - 1)
			lane = lane_t'((int'(current) + NUM_LANES - 1) % NUM_LANES);
		else
			lane = current;
	end

	assign spawn_x = x_coord_t'(LANE_X0 + int'(lane) * LANE_PITCH);

endmodule

// ==== verilog/block_store.sv ====
// Block slot registers for the falling-block engine
// Steps live blocks down a row, loads the new block round robin, reads one slot out

`timescale 1ns/1ps

module block_store #(
	parameter int NUM_BLOCKS = 5,
	localparam int SLOT_W = (NUM_BLOCKS > 1) ? $clog2(NUM_BLOCKS) : 1
) (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      advance,
	input  block_game_pkg::x_coord_t  spawn_x,
	input  logic [SLOT_W-1:0]         slot_index,
	output block_game_pkg::x_coord_t  slot_x,
	output block_game_pkg::y_coord_t  slot_y
);
	import block_game_pkg::*;

	x_coord_t          block_x [NUM_BLOCKS];
	y_coord_t          block_y [NUM_BLOCKS];  // Zero row means empty slot
	logic [SLOT_W-1:0] load_ptr;

	always_ff @(posedge clock)
	begin
		if (!reset)
		begin
			load_ptr <= '0;
			for (int i = 0; i < NUM_BLOCKS; i++)
			begin
				block_x[i] <= '0;
				block_y[i] <= '0;
			end
		end
		else if (advance)
		begin
			for (int i = 0; i < NUM_BLOCKS; i++)
			begin
				if (SLOT_W'(i) == load_ptr)
				begin
					block_x[i] <= spawn_x;       // New block at the top
					block_y[i] <= y_coord_t'(TOP_Y);
				end
				else if (block_y[i] == y_coord_t'(BOTTOM_Y))
				begin
					block_x[i] <= '0;            // Falls off the bottom
					block_y[i] <= '0;
				end
				else if (block_y[i] != '0)
					block_y[i] <= block_y[i] + y_coord_t'(LANE_PITCH);
			end
			if (load_ptr == SLOT_W'(NUM_BLOCKS - 1))
				load_ptr <= '0;
			else
				load_ptr <= load_ptr + 1'b1;
		end
	end

	assign slot_x = block_x[slot_index];
	assign slot_y = block_y[slot_index];

endmodule

// ==== verilog/block_plotter.sv ====
// Pixel sweep over all block slots
// Column, row and slot counters turn slot positions into one pixel write per cycle

`timescale 1ns/1ps

module block_plotter #(
	parameter int NUM_BLOCKS = 5,
	localparam int SLOT_W = (NUM_BLOCKS > 1) ? $clog2(NUM_BLOCKS) : 1
) (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      sweep,
	input  logic                      erase,
	input  block_game_pkg::x_coord_t  slot_x,
	input  block_game_pkg::y_coord_t  slot_y,
	output logic [SLOT_W-1:0]         slot_index,
	output block_game_pkg::x_coord_t  x,
	output block_game_pkg::y_coord_t  y,
	output block_game_pkg::colour_t   colour,
	output logic                      write_enable,
	output logic                      sweep_done
);
	import block_game_pkg::*;

	localparam int CNT_W = $clog2(BLOCK_SIZE);

	logic [CNT_W-1:0] column;
	logic [CNT_W-1:0] row;
	logic             column_last;
	logic             row_last;
	logic             slot_last;

	assign column_last = (column == CNT_W'(BLOCK_SIZE - 1));
	assign row_last    = (row == CNT_W'(BLOCK_SIZE - 1));
	assign slot_last   = (slot_index == SLOT_W'(NUM_BLOCKS - 1));

	// Column fastest, then row, then slot
	always_ff @(posedge clock)
	begin
		if (!reset || !sweep)
		begin
			column     <= '0;
			row        <= '0;
			slot_index <= '0;
		end
		else if (!column_last)
			column <= column + 1'b1;
		else
		begin
			column <= '0;
			if (!row_last)
				row <= row + 1'b1;
			else
			begin
				row        <= '0;
				slot_index <= slot_last ? '0 : slot_index + 1'b1;
			end
		end
	end

	assign x            = slot_x + x_coord_t'(column);
	assign y            = slot_y + y_coord_t'(row);
	assign colour       = (erase || x < x_coord_t'(BLOCK_SIZE)) ? BACKGROUND : BLOCK_COLOUR;
	assign write_enable = sweep;
	assign sweep_done   = sweep && column_last && row_last && slot_last;  // Last pixel

endmodule

// ==== verilog/block_game.sv ====
// Falling-block display engine top level
// Round controller, hold timer, lane picker, block store and pixel plotter

`timescale 1ns/1ps

module block_game #(
	parameter int NUM_BLOCKS  = 5,
	parameter int HOLD_CYCLES = 166
) (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      start,
	output block_game_pkg::x_coord_t  x,
	output block_game_pkg::y_coord_t  y,
	output block_game_pkg::colour_t   colour,
	output logic                      write_enable
);
	import block_game_pkg::*;

	localparam int SLOT_W = (NUM_BLOCKS > 1) ? $clog2(NUM_BLOCKS) : 1;

	logic              capture;
	logic              advance;
	logic              sweep;
	logic              erase;
	logic              hold;
	logic              sweep_done;
	logic              hold_done;
	x_coord_t          spawn_x;
	x_coord_t          slot_x;
	y_coord_t          slot_y;
	logic [SLOT_W-1:0] slot_index;

	game_control control_i (
		.clock(clock), .reset(reset), .start(start),
		.sweep_done(sweep_done), .hold_done(hold_done),
		.capture(capture), .advance(advance), .sweep(sweep), .erase(erase), .hold(hold)
	);

	frame_timer #(.HOLD_CYCLES(HOLD_CYCLES)) timer_i (
		.clock(clock), .reset(reset), .hold(hold), .hold_done(hold_done)
	);

	lane_picker picker_i (
		.clock(clock), .reset(reset), .capture(capture), .spawn_x(spawn_x)
	);

	block_store #(.NUM_BLOCKS(NUM_BLOCKS)) store_i (
		.clock(clock), .reset(reset), .advance(advance), .spawn_x(spawn_x),
		.slot_index(slot_index), .slot_x(slot_x), .slot_y(slot_y)
	);

	block_plotter #(.NUM_BLOCKS(NUM_BLOCKS)) plotter_i (
		.clock(clock), .reset(reset), .sweep(sweep), .erase(erase),
		.slot_x(slot_x), .slot_y(slot_y), .slot_index(slot_index),
		.x(x), .y(y), .colour(colour), .write_enable(write_enable),
		.sweep_done(sweep_done)
	);

endmodule

// ==== tests/block_game_assert.sv ====
// Port checks for the falling-block engine
// Burst and gap timing, erase colour, block placement and block counts per round

`timescale 1ns/1ps

module block_game_assert #(
	parameter int NUM_BLOCKS  = 5,
	parameter int HOLD_CYCLES = 166
) (
	input logic                      clock,
	input logic                      reset,
	input logic                      start,
	input block_game_pkg::x_coord_t  x,
	input block_game_pkg::y_coord_t  y,
	input block_game_pkg::colour_t   colour,
	input logic                      write_enable
);
	import block_game_pkg::*;

	localparam int BLOCK_PIXELS = BLOCK_SIZE * BLOCK_SIZE;
	localparam int SWEEP_PIXELS = NUM_BLOCKS * BLOCK_PIXELS;

	int   failures;
	int   burst_len;
	int   gap_len;
	int   bursts;       // Completed write bursts
	int   block_count;
	int   top_count;
	logic pressed;
	logic released;
	logic we_q;

	initial failures = 0;

	// Inside a lane column or block row with a one pixel gap per pitch
	function automatic bit on_grid(input int pos, input int origin);
		return (pos >= origin) && ((pos - origin) % LANE_PITCH < BLOCK_SIZE);
	endfunction

	function automatic int expected_blocks(input int done_bursts);
		int round_no;
		round_no = done_bursts / 2 + 1;
		return BLOCK_PIXELS * ((round_no < NUM_BLOCKS) ? round_no : NUM_BLOCKS);
	endfunction

	// ####################
	// Helper counters
	// ####################

	always_ff @(posedge clock)
	begin
		if (!reset)
		begin
			pressed     <= 1'b0;
			released    <= 1'b0;
			we_q        <= 1'b0;
			burst_len   <= 0;
			gap_len     <= 0;
			bursts      <= 0;
			block_count <= 0;
			top_count   <= 0;
		end
		else
		begin
			we_q <= write_enable;
			if (start)
				pressed <= 1'b1;
			else if (pressed)
				released <= 1'b1;
			burst_len <= write_enable ? burst_len + 1 : 0;
			gap_len   <= write_enable ? 0 : gap_len + 1;
			if (we_q && !write_enable)
				bursts <= bursts + 1;
			if (!write_enable)
			begin
				block_count <= 0;
				top_count   <= 0;
			end
			else if (colour == BLOCK_COLOUR)
			begin
				block_count <= block_count + 1;
				if (int'(y) < TOP_Y + BLOCK_SIZE)
					top_count <= top_count + 1;  // Newly spawned row
			end
		end
	end

	// ####################
	// Assertions
	// ####################

	no_write_before_release: assert property (@(posedge clock) disable iff (!reset)
		write_enable |-> released)
		else
		begin
			$error("pixel written before start was released");
			failures++;
		end

	burst_length: assert property (@(posedge clock) disable iff (!reset)
		(we_q && !write_enable) |-> burst_len == SWEEP_PIXELS)
		else
		begin
			$error("write burst lasted %0d cycles", burst_len);
			failures++;
		end

	gap_length: assert property (@(posedge clock) disable iff (!reset)
		(!we_q && write_enable && bursts > 0) |->
			gap_len == ((bursts % 2 == 1) ? HOLD_CYCLES : 2))
		else
		begin
			$error("gap of %0d cycles after burst %0d", gap_len, bursts);
			failures++;
		end

	erase_colour: assert property (@(posedge clock) disable iff (!reset)
		(write_enable && bursts % 2 == 1) |-> colour == BACKGROUND)
		else
		begin
			$error("erase pixel with colour %0d", colour);
			failures++;
		end

	block_placement: assert property (@(posedge clock) disable iff (!reset)
		(write_enable && colour == BLOCK_COLOUR) |->
			on_grid(int'(x), LANE_X0) && on_grid(int'(y), TOP_Y))
		else
		begin
			$error("block pixel off grid at %0d,%0d", x, y);
			failures++;
		end

	draw_count: assert property (@(posedge clock) disable iff (!reset)
		(we_q && !write_enable && bursts % 2 == 0) |->
			block_count == expected_blocks(bursts))
		else
		begin
			$error("draw burst had %0d block pixels", block_count);
			failures++;
		end

	spawn_count: assert property (@(posedge clock) disable iff (!reset)
		(we_q && !write_enable && bursts % 2 == 0) |-> top_count == BLOCK_PIXELS)
		else
		begin
			$error("draw burst had %0d top row pixels", top_count);
			failures++;
		end

endmodule

bind block_game block_game_assert #(
	.NUM_BLOCKS(NUM_BLOCKS),
	.HOLD_CYCLES(HOLD_CYCLES)
) assert_i (.*);

// ==== tests/block_game_tb.sv ====
// Testbench for the falling-block engine
// Start press, then eight rounds of draw, hold and erase checked by bound assertions

`timescale 1ns/1ps

module block_game_tb;
	import block_game_pkg::*;

	localparam int TIMEOUT = 10000;  // Cycles, longer than any burst or gap
	localparam int ROUNDS  = 8;

	logic     clock;
	logic     reset;
	logic     start;
	x_coord_t x;
	y_coord_t y;
	colour_t  colour;
	logic     write_enable;

	int tests_run;
	int tests_failed;
	int mark;
	int idle_len;
	int press_len;
	bit ok;

	block_game dut_i (.*);

	always #2 clock = ~clock;

	task automatic wait_for_write(input logic level, input int limit, output bit seen);
		int n;
		n = 0;
		while (write_enable !== level && n < limit)
		begin
			@(negedge clock);
			n++;
		end
		seen = (write_enable === level);
	endtask

	task automatic finish_test(input string name, input bit progressed);
		int errs;
		errs = dut_i.assert_i.failures - mark;
		tests_run++;
		if (!progressed)
		begin
			tests_failed++;
			$display("Test %s: timed out waiting for write_enable", name);
		end
		else if (errs != 0)
		begin
			tests_failed++;
			$display("** Error %0t: test %s saw %0d assertion failures", $time, name, errs);
		end
		else
			$display("Test %s: ok", name);
		mark = dut_i.assert_i.failures;
	endtask

	initial
	begin
		clock        = 1'b0;
		reset        = 1'b0;
		start        = 1'b0;
		tests_run    = 0;
		tests_failed = 0;
		mark         = 0;
		void'($urandom(5));
		repeat (5) @(posedge clock);
		@(negedge clock);
		reset = 1'b1;

		// Random idle time and press length before the release
		idle_len  = 2 + int'($urandom % 8);
		press_len = 3 + int'($urandom % 38);
		repeat (idle_len) @(negedge clock);
		start = 1'b1;
		repeat (press_len) @(negedge clock);
		start = 1'b0;
		wait_for_write(1'b1, 8, ok);
		finish_test("start press", ok);

		for (int round = 1; round <= ROUNDS && ok; round++)
		begin
			wait_for_write(1'b0, TIMEOUT, ok);          // Draw done
			if (ok)
				wait_for_write(1'b1, TIMEOUT, ok);      // Erase starts
			if (ok)
				wait_for_write(1'b0, TIMEOUT, ok);
			if (ok)
				wait_for_write(1'b1, TIMEOUT, ok);      // Next draw
			finish_test($sformatf("round %0d", round), ok);
		end

		$display("Tests run %0d, failed %0d, assertion failures %0d",
			tests_run, tests_failed, dut_i.assert_i.failures);
		if (ok && tests_failed == 0 && dut_i.assert_i.failures == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// ==== verilog.f ====
verilog/block_game_pkg.sv
verilog/frame_timer.sv
verilog/game_control.sv
verilog/lane_picker.sv
verilog/block_store.sv
verilog/block_plotter.sv
verilog/block_game.sv
tests/block_game_assert.sv
tests/block_game_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module block_game_tb -f verilog.f
./obj_dir/Vblock_game_tb +verilator+error+limit+1000 | tee sim.log

if grep -q "Testbench passed" sim.log; then
	exit 0
else
	exit 1
fi
